/* compile.f */
source/dcache_pkg.sv
source/dcache_tag_array.sv
source/dcache_data_array.sv
source/dcache_ctrl.sv
source/dcache_top.sv
testbench/dcache_mem_model.sv
testbench/dcache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the dcache testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb \
    -f compile.f -o dcache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/dcache_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Test OK$"; then
    exit 0
fi
exit 1

/* testbench/dcache_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_tb import dcache_pkg::*; ();

    localparam int SETS        = 16;
    localparam int LINE_WORDS  = 4;
    localparam int LINE_B      = LINE_WORDS * 4;  // bytes per line
    localparam int MEM_AW      = 12;
    localparam int ACK_TIMEOUT = 400;

    logic              clk, rst;
    logic              cyc, stb, we;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] wdat;
    logic [SEL_W-1:0]  sel;
    wire  [DATA_W-1:0] rdat, mem_wdat, mem_rdat;
    wire  [ADDR_W-1:0] mem_adr;
    wire               ack, mem_cyc, mem_stb, mem_we, mem_ack;

    // reference model with coherent memory image and tag state of both ways
    logic [DATA_W-1:0] ref_mem [2**MEM_AW];
    int                ref_tag [SETS][2];
    bit                ref_vld [SETS][2];
    bit                ref_dty [SETS][2];
    bit                ref_ru  [SETS];  // way used last

    bit                exp_hit;
    int                exp_rd, exp_wr;
    logic [DATA_W-1:0] exp_dat;
    logic [ADDR_W-1:0] line_base, wb_base;
    int                rd_total, wr_total, rd_mark, wr_mark;
    int                err_count, test_mark, tests_pass, tests_fail;
    integer            seed;

    dcache_top #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) uut (
        .clk, .rst,
        .cpu_cyc_i(cyc), .cpu_stb_i(stb), .cpu_we_i(we), .cpu_adr_i(adr),
        .cpu_dat_i(wdat), .cpu_sel_i(sel), .cpu_dat_o(rdat), .cpu_ack_o(ack),
        .mem_cyc_o(mem_cyc), .mem_stb_o(mem_stb), .mem_we_o(mem_we), .mem_adr_o(mem_adr),
        .mem_dat_o(mem_wdat), .mem_dat_i(mem_rdat), .mem_ack_i(mem_ack)
    );

    dcache_mem_model #(.AW(MEM_AW)) u_mem (
        .clk, .rst, .cyc_i(mem_cyc), .stb_i(mem_stb), .we_i(mem_we), .adr_i(mem_adr),
        .dat_i(mem_wdat), .dat_o(mem_rdat), .ack_o(mem_ack)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (mem_ack && mem_we) wr_total <= wr_total + 1;
        if (mem_ack && !mem_we) rd_total <= rd_total + 1;
    end

    // write-back walks the victim line, refill the requested line
    wire [ADDR_W-1:0] exp_adr = mem_we ? wb_base + ADDR_W'(4 * (wr_total - wr_mark))
                                       : line_base + ADDR_W'(4 * (rd_total - rd_mark));

    function automatic void flag_mismatch(input string name, input logic [31:0] got, exp);
        err_count++;
        $display("ERROR %0t: %s = %0h, expected %0h", $time, name, got, exp);
    endfunction

    a_rd_data: assert property (@(posedge clk) disable iff (rst)
        ack && !we |-> rdat == exp_dat) else flag_mismatch("cpu_dat_o", rdat, exp_dat);
    a_hit_time: assert property (@(posedge clk) disable iff (rst)
        $rose(stb) |=> ack == exp_hit) else flag_mismatch("cpu_ack_o", ack, exp_hit);
    a_no_mem: assert property (@(posedge clk) disable iff (rst)
        stb && exp_hit |-> !mem_cyc) else flag_mismatch("mem_cyc_o", mem_cyc, 0);
    a_stb_cyc: assert property (@(posedge clk) disable iff (rst)
        !mem_cyc |-> !mem_stb) else flag_mismatch("mem_stb_o", mem_stb, 0);
    a_mem_adr: assert property (@(posedge clk) disable iff (rst)
        mem_ack |-> mem_adr == exp_adr) else flag_mismatch("mem_adr_o", mem_adr, exp_adr);
    a_wb_dat: assert property (@(posedge clk) disable iff (rst)
        mem_ack && mem_we |-> mem_wdat == ref_mem[mem_adr[MEM_AW+1:2]])
        else flag_mismatch("mem_dat_o", mem_wdat, ref_mem[mem_adr[MEM_AW+1:2]]);
    a_rd_count: assert property (@(posedge clk) disable iff (rst)
        ack |-> rd_total - rd_mark == exp_rd)
        else flag_mismatch("memory reads", rd_total - rd_mark, exp_rd);
    a_wr_count: assert property (@(posedge clk) disable iff (rst)
        ack |-> wr_total - wr_mark == exp_wr)
        else flag_mismatch("memory writes", wr_total - wr_mark, exp_wr);
    a_ack_req: assert property (@(posedge clk) disable iff (rst) ack |-> cyc && stb)
        else begin
            err_count++;
            $display("ack at %0t without a pending request", $time);
        end

    // hit or victim by the replacement rules, then update the tag state
    function automatic void predict(input logic [ADDR_W-1:0] a, input bit wr);
        int line, s, t, v;
        line = int'(a / LINE_B);
        s = line % SETS;
        t = line / SETS;
        v = 0;
        exp_hit = 0;
        exp_rd = 0;
        exp_wr = 0;
        for (int w = 0; w < 2; w++) begin
            if (ref_vld[s][w] && ref_tag[s][w] == t) begin
                exp_hit = 1;
                v = w;
            end
        end
        if (!exp_hit) begin
            v = !ref_vld[s][0] ? 0 : (!ref_vld[s][1] ? 1 : int'(!ref_ru[s]));
            exp_rd = LINE_WORDS;
            exp_wr = (ref_vld[s][v] && ref_dty[s][v]) ? LINE_WORDS : 0;
            wb_base = ADDR_W'((ref_tag[s][v] * SETS + s) * LINE_B);
            ref_tag[s][v] = t;
            ref_vld[s][v] = 1;
            ref_dty[s][v] = 0;
        end
        ref_dty[s][v] = ref_dty[s][v] | wr;
        ref_ru[s] = v[0];
        line_base = ADDR_W'(line * LINE_B);
    endfunction

    task automatic access(input logic [ADDR_W-1:0] a, input bit wr,
                          input logic [SEL_W-1:0] s, input logic [DATA_W-1:0] d);
        int n;
        int w;
        @(posedge clk);
        #10;
        w = int'(a[MEM_AW+1:2]);
        predict(a, wr);
        for (int b = 0; b < SEL_W; b++) begin
            if (wr && s[b]) ref_mem[w][8*b +: 8] = d[8*b +: 8];
        end
        exp_dat = ref_mem[w];
        rd_mark = rd_total;
        wr_mark = wr_total;
        cyc = 1;
        stb = 1;
        we = wr;
        adr = a;
        sel = s;
        wdat = d;
        n = 0;
        @(negedge clk);
        while (!ack && n < ACK_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!ack) begin
            err_count++;
            $display("no cpu ack within %0d cycles for address %h", ACK_TIMEOUT, a);
        end
        @(posedge clk);
        #10;
        cyc = 0;
        stb = 0;
        we = 0;
    endtask

    task automatic finish_test(input string name);
        if (err_count == test_mark) begin
            tests_pass++;
            $display("%s: passed", name);
        end else begin
            tests_fail++;
            $display("%s: failed with %0d errors", name, err_count - test_mark);
        end
        test_mark = err_count;
    endtask

    initial begin
        logic [31:0] r;
        logic [SEL_W-1:0] rs;
        seed = 32'h5869;
        clk = 0;
        rst = 1;
        cyc = 0;
        stb = 0;
        we = 0;
        adr = '0;
        wdat = '0;
        sel = '0;
        #1;
        for (int i = 0; i < 2**MEM_AW; i++) ref_mem[i] = u_mem.mem_q[i];
        repeat (4) @(posedge clk);
        #10 rst = 0;

        access(32'h0224, 0, 4'hf, '0);  // cold line in set 2
        finish_test("cold read miss");
        access(32'h0228, 0, 4'hf, '0);
        finish_test("read hit in same line");
        access(32'h022c, 1, 4'b0110, 32'hdead_beef);
        access(32'h022c, 0, 4'hf, '0);
        finish_test("partial write hit");

        // A, B, A, C in set 5 so C replaces B
        access(32'h0350, 0, 4'hf, '0);
        access(32'h0450, 0, 4'hf, '0);
        access(32'h0350, 0, 4'hf, '0);
        access(32'h0550, 0, 4'hf, '0);
        access(32'h0350, 0, 4'hf, '0);
        access(32'h0450, 0, 4'hf, '0);
        finish_test("least recently used eviction");

        access(32'h0360, 1, 4'hf, 32'h1234_5678);
        access(32'h0364, 1, 4'b1001, 32'haabb_ccdd);
        access(32'h0460, 0, 4'hf, '0);
        access(32'h0560, 0, 4'hf, '0);  // dirty 0x360 line goes out
        access(32'h0360, 0, 4'hf, '0);
        access(32'h0364, 0, 4'hf, '0);
        finish_test("dirty write-back and reload");

        for (int i = 0; i < 200; i++) begin
            r = $random(seed);
            rs = (r[11:8] == 0) ? 4'hf : r[11:8];
            access(32'(((r[2:0] * SETS + r[4:3]) * LINE_WORDS + r[6:5]) * 4),
                   r[7], rs, $random(seed));
        end
        finish_test("random loads and stores");

        $display("tests passed: %0d, failed: %0d", tests_pass, tests_fail);
        if (tests_fail == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/dcache_mem_model.sv */
`timescale 1ns/100ps
`default_nettype none

// wishbone classic memory acking after a random 0..3 cycle delay
module dcache_mem_model #(
    parameter int AW = 12  // word address bits
) (
    input  wire         clk,
    input  wire         rst,
    input  wire         cyc_i,
    input  wire         stb_i,
    input  wire         we_i,
    input  wire  [31:0] adr_i,
    input  wire  [31:0] dat_i,
    output logic [31:0] dat_o,
    output logic        ack_o
);

    logic [31:0] mem_q [2**AW];  // testbench reads this as its shadow
    logic [1:0]  wait_q;
    logic        busy_q;         // delay already drawn for this transfer
    integer      seed;
    integer      dly;

    initial begin
        seed  = 32'h5869;
        ack_o = 1'b0;
        dat_o = '0;
        // odd multiplier so every word differs
        for (int i = 0; i < 2**AW; i++) begin
            mem_q[i] = ((32'(i) << 2) * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            ack_o  <= 1'b0;
            busy_q <= 1'b0;
            wait_q <= '0;
        end else begin
            ack_o <= 1'b0;  // one cycle pulse
            if (cyc_i && stb_i && !ack_o) begin
                dly = busy_q ? int'(wait_q) : ($random(seed) & 3);
                if (dly == 0) begin
                    ack_o  <= 1'b1;
                    busy_q <= 1'b0;
                    dat_o  <= mem_q[adr_i[AW+1:2]];
                    if (we_i) begin
                        mem_q[adr_i[AW+1:2]] <= dat_i;
                    end
                end else begin
                    busy_q <= 1'b1;
                    wait_q <= 2'(dly - 1);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/dcache_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_top
    import dcache_pkg::*;
#(
    parameter int SETS       = 16,
    parameter int LINE_WORDS = 4,
    localparam int IDX_W     = $clog2(SETS),
    localparam int OFF_W     = $clog2(LINE_WORDS),
    localparam int TVD_W     = ADDR_W - IDX_W - OFF_W,  // tag + valid + dirty
    localparam int LINE_W    = LINE_WORDS * DATA_W
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               cpu_cyc_i,
    input  wire               cpu_stb_i,
    input  wire               cpu_we_i,
    input  wire  [ADDR_W-1:0] cpu_adr_i,
    input  wire  [DATA_W-1:0] cpu_dat_i,
    input  wire  [SEL_W-1:0]  cpu_sel_i,
    output wire  [DATA_W-1:0] cpu_dat_o,
    output wire               cpu_ack_o,
    output wire               mem_cyc_o,
    output wire               mem_stb_o,
    output wire               mem_we_o,
    output wire  [ADDR_W-1:0] mem_adr_o,
    output wire  [DATA_W-1:0] mem_dat_o,
    input  wire  [DATA_W-1:0] mem_dat_i,
    input  wire               mem_ack_i
);

    wire [TVD_W-1:0]  tag_rdata0, tag_rdata1, tag_wdata;
    wire [1:0]        tag_wen, data_wen;
    wire [IDX_W-1:0]  tag_index, data_index;
    wire [OFF_W-1:0]  data_word;
    wire [DATA_W-1:0] data_wdata, data_rword0, data_rword1;
    wire [SEL_W-1:0]  data_wmask;
    wire [LINE_W-1:0] data_rline0, data_rline1;

    dcache_ctrl #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) u_ctrl (
        .clk, .rst,
        .cpu_cyc_i, .cpu_stb_i, .cpu_we_i, .cpu_adr_i, .cpu_dat_i, .cpu_sel_i,
        .cpu_dat_o, .cpu_ack_o,
        .mem_cyc_o, .mem_stb_o, .mem_we_o, .mem_adr_o, .mem_dat_o,
        .mem_dat_i, .mem_ack_i,
        .tag_rdata0_i(tag_rdata0), .tag_rdata1_i(tag_rdata1),
        .tag_wen_o(tag_wen), .tag_index_o(tag_index), .tag_wdata_o(tag_wdata),
        .data_index_o(data_index), .data_word_o(data_word),
        .data_wdata_o(data_wdata), .data_wmask_o(data_wmask), .data_wen_o(data_wen),
        .data_rword0_i(data_rword0), .data_rword1_i(data_rword1),
        .data_rline0_i(data_rline0), .data_rline1_i(data_rline1)
    );

    // way 0
    dcache_tag_array #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) u_tag0 (
        .clk, .rst, .raddr_i(tag_index), .waddr_i(tag_index),
        .wen_i(tag_wen[0]), .din_i(tag_wdata), .dout_o(tag_rdata0)
    );

    dcache_data_array #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) u_data0 (
        .clk, .rst, .index_i(data_index), .word_i(data_word), .wen_i(data_wen[0]),
        .wdata_i(data_wdata), .wmask_i(data_wmask),
        .rword_o(data_rword0), .rline_o(data_rline0)
    );

    // way 1
    dcache_tag_array #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) u_tag1 (
        .clk, .rst, .raddr_i(tag_index), .waddr_i(tag_index),
        .wen_i(tag_wen[1]), .din_i(tag_wdata), .dout_o(tag_rdata1)
    );

    dcache_data_array #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) u_data1 (
        .clk, .rst, .index_i(data_index), .word_i(data_word), .wen_i(data_wen[1]),
        .wdata_i(data_wdata), .wmask_i(data_wmask),
        .rword_o(data_rword1), .rline_o(data_rline1)
    );

endmodule

`default_nettype wire

/* source/dcache_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter int SETS       = 16,
    parameter int LINE_WORDS = 4,
    localparam int IDX_W     = $clog2(SETS),
    localparam int OFF_W     = $clog2(LINE_WORDS),
    localparam int TAG_W     = ADDR_W - IDX_W - OFF_W - 2,
    localparam int TVD_W     = TAG_W + 2,
    localparam int LINE_W    = LINE_WORDS * DATA_W
) (
    input  wire               clk,
    input  wire               rst,
    // cpu side wishbone slave
    input  wire               cpu_cyc_i,
    input  wire               cpu_stb_i,
    input  wire               cpu_we_i,
    input  wire  [ADDR_W-1:0] cpu_adr_i,
    input  wire  [DATA_W-1:0] cpu_dat_i,
    input  wire  [SEL_W-1:0]  cpu_sel_i,
    output logic [DATA_W-1:0] cpu_dat_o,
    output logic              cpu_ack_o,
    // memory side wishbone master
    output logic              mem_cyc_o,
    output logic              mem_stb_o,
    output logic              mem_we_o,
    output logic [ADDR_W-1:0] mem_adr_o,
    output logic [DATA_W-1:0] mem_dat_o,
    input  wire  [DATA_W-1:0] mem_dat_i,
    input  wire               mem_ack_i,
    // tag arrays
    input  wire  [TVD_W-1:0]  tag_rdata0_i,
    input  wire  [TVD_W-1:0]  tag_rdata1_i,
    output logic [1:0]        tag_wen_o,
    output logic [IDX_W-1:0]  tag_index_o,
    output logic [TVD_W-1:0]  tag_wdata_o,
    // data arrays
    output logic [IDX_W-1:0]  data_index_o,
    output logic [OFF_W-1:0]  data_word_o,
    output logic [DATA_W-1:0] data_wdata_o,
    output logic [SEL_W-1:0]  data_wmask_o,
    output logic [1:0]        data_wen_o,
    input  wire  [DATA_W-1:0] data_rword0_i,
    input  wire  [DATA_W-1:0] data_rword1_i,
    input  wire  [LINE_W-1:0] data_rline0_i,
    input  wire  [LINE_W-1:0] data_rline1_i
);

    localparam logic [OFF_W-1:0] LAST_WORD = OFF_W'(LINE_WORDS - 1);

    cache_state_t      state_q;
    cache_op_t         op_q;
    logic [ADDR_W-3:0] wadr_q;     // word address of the request
    logic [DATA_W-1:0] wdat_q;
    logic [SEL_W-1:0]  sel_q;
    logic              victim_q;   // way being replaced
    logic [OFF_W-1:0]  cnt_q;      // word within the line on the bus
    logic [SETS-1:0]   ru_q;       // set when way 1 used last

    logic [TAG_W-1:0]  req_tag;
    logic [IDX_W-1:0]  req_idx;
    logic [OFF_W-1:0]  req_word;
    logic              valid0, valid1, dirty0, dirty1;
    logic              hit0, hit1, hit;
    logic              victim, victim_dirty, last_word, rd_way;
    logic              hit_wr, refill_wr, done_wr;
    logic [TAG_W-1:0]  victim_tag;
    logic [LINE_W-1:0] victim_line;

    assign {req_tag, req_idx, req_word} = wadr_q;

    assign valid0 = tag_rdata0_i[1];
    assign dirty0 = tag_rdata0_i[0];
    assign valid1 = tag_rdata1_i[1];
    assign dirty1 = tag_rdata1_i[0];

    // only a valid way can hit
    assign hit0 = valid0 && (tag_rdata0_i[TVD_W-1:2] == req_tag);
    assign hit1 = valid1 && (tag_rdata1_i[TVD_W-1:2] == req_tag);
    assign hit  = hit0 || hit1;

    // empty way first, way 0 preferred; else the one not used last
    assign victim       = !valid0 ? 1'b0 : (!valid1 ? 1'b1 : ~ru_q[req_idx]);
    assign victim_dirty = victim ? (valid1 && dirty1) : (valid0 && dirty0);

    assign victim_tag  = victim_q ? tag_rdata1_i[TVD_W-1:2] : tag_rdata0_i[TVD_W-1:2];
    assign victim_line = victim_q ? data_rline1_i : data_rline0_i;
    assign last_word   = (cnt_q == LAST_WORD);

    // request capture
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && cpu_cyc_i && cpu_stb_i) begin
            wadr_q <= cpu_adr_i[ADDR_W-1:2];
            wdat_q <= cpu_dat_i;
            sel_q  <= cpu_sel_i;
            op_q   <= cpu_we_i ? OP_WRITE : OP_READ;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= S_IDLE;
            victim_q <= 1'b0;
            cnt_q    <= '0;
            ru_q     <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (cpu_cyc_i && cpu_stb_i) begin
                        state_q <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    if (hit) begin
                        ru_q[req_idx] <= hit1;
                        state_q       <= S_IDLE;
                    end else begin
                        victim_q <= victim;
                        cnt_q    <= '0;
                        state_q  <= victim_dirty ? S_WBACK : S_REFILL;
                    end
                end
                S_WBACK: begin
                    if (mem_ack_i) begin  // counter waits on ack
                        cnt_q <= last_word ? '0 : cnt_q + 1'b1;
                        if (last_word) begin
                            state_q <= S_REFILL;
                        end
                    end
                end
                S_REFILL: begin
                    if (mem_ack_i) begin
                        cnt_q <= last_word ? '0 : cnt_q + 1'b1;
                        if (last_word) begin
                            state_q <= S_DONE;
                        end
                    end
                end
                S_DONE: begin
                    ru_q[req_idx] <= victim_q;
                    state_q       <= S_IDLE;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // cyc held over write-back and refill
    assign mem_cyc_o = (state_q == S_WBACK) || (state_q == S_REFILL);
    assign mem_stb_o = mem_cyc_o;
    assign mem_we_o  = (state_q == S_WBACK);
    assign mem_adr_o = {mem_we_o ? victim_tag : req_tag, req_idx, cnt_q, 2'b00};
    assign mem_dat_o = victim_line[cnt_q*DATA_W +: DATA_W];

    // cpu port
    assign rd_way    = (state_q == S_DONE) ? victim_q : hit1;
    assign cpu_dat_o = rd_way ? data_rword1_i : data_rword0_i;
    assign cpu_ack_o = (state_q == S_LOOKUP && hit) || (state_q == S_DONE);

    assign hit_wr    = (state_q == S_LOOKUP) && hit && (op_q == OP_WRITE);
    assign refill_wr = (state_q == S_REFILL) && mem_ack_i;
    assign done_wr   = (state_q == S_DONE) && (op_q == OP_WRITE);

    // store hit sets dirty and refill installs the new tag
    assign tag_index_o = req_idx;
    assign tag_wdata_o = {req_tag, 1'b1, op_q == OP_WRITE};
    always_comb begin
        tag_wen_o = 2'b00;
        if (hit_wr) begin
            tag_wen_o = {hit1, hit0};
        end else if (state_q == S_DONE) begin
            tag_wen_o = {victim_q, ~victim_q};
        end
    end

    assign data_index_o = req_idx;
    assign data_word_o  = (state_q == S_WBACK || state_q == S_REFILL) ? cnt_q : req_word;
    assign data_wdata_o = (state_q == S_REFILL) ? mem_dat_i : wdat_q;
    assign data_wmask_o = (state_q == S_REFILL) ? '1 : sel_q;  // refill writes whole words
    always_comb begin
        data_wen_o = 2'b00;
        if (hit_wr) begin
            data_wen_o = {hit1, hit0};
        end else if (refill_wr || done_wr) begin
            data_wen_o = {victim_q, ~victim_q};
        end
    end

    a_ack_req: assert property (
        @(posedge clk) disable iff (rst)
        cpu_ack_o |-> cpu_cyc_i && cpu_stb_i
    );

    // a tag may live in one way only
    a_one_hit: assert property (
        @(posedge clk) disable iff (rst)
        state_q == S_LOOKUP |-> !(hit0 && hit1)
    );

    a_adr_hold: assert property (
        @(posedge clk) disable iff (rst)
        mem_stb_o && !mem_ack_i |=> $stable(mem_adr_o)
    );

endmodule

`default_nettype wire

/* source/dcache_data_array.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_data_array
    import dcache_pkg::*;
#(
    parameter int SETS       = 16,
    parameter int LINE_WORDS = 4,
    localparam int IDX_W     = $clog2(SETS),
    localparam int OFF_W     = $clog2(LINE_WORDS),
    localparam int LINE_W    = LINE_WORDS * DATA_W
) (
    input  wire               clk,
    input  wire               rst,
    input  wire  [IDX_W-1:0]  index_i,
    input  wire  [OFF_W-1:0]  word_i,
    input  wire               wen_i,
    input  wire  [DATA_W-1:0] wdata_i,
    input  wire  [SEL_W-1:0]  wmask_i,
    output logic [DATA_W-1:0] rword_o,
    output logic [LINE_W-1:0] rline_o
);

    logic [DATA_W-1:0] mem_q [SETS][LINE_WORDS];

    // byte-masked write of one word
    always_ff @(posedge clk) begin
        if (wen_i && !rst) begin  // nothing lands while in reset
            for (int b = 0; b < SEL_W; b++) begin
                if (wmask_i[b]) begin
                    mem_q[index_i][word_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    assign rword_o = mem_q[index_i][word_i];

    // whole line for write-back with word 0 in the low bits
    always_comb begin
        for (int w = 0; w < LINE_WORDS; w++) begin
            rline_o[w*DATA_W +: DATA_W] = mem_q[index_i][w];
        end
    end

endmodule

`default_nettype wire

/* source/dcache_tag_array.sv */
`timescale 1ns/100ps
`default_nettype none

// one way of tag/valid/dirty entries laid out as {tag, valid, dirty}
module dcache_tag_array
    import dcache_pkg::*;
#(
    parameter int SETS       = 16,
    parameter int LINE_WORDS = 4,
    localparam int IDX_W     = $clog2(SETS),
    localparam int TAG_W     = ADDR_W - IDX_W - $clog2(LINE_WORDS) - 2,
    localparam int TVD_W     = TAG_W + 2
) (
    input  wire              clk,
    input  wire              rst,
    input  wire  [IDX_W-1:0] raddr_i,
    input  wire  [IDX_W-1:0] waddr_i,
    input  wire              wen_i,
    input  wire  [TVD_W-1:0] din_i,
    output logic [TVD_W-1:0] dout_o
);

    logic [TAG_W-1:0] tag_q [SETS];
    logic [SETS-1:0]  valid_q;
    logic [SETS-1:0]  dirty_q;

    // tag field of each entry
    always_ff @(posedge clk) begin
        if (wen_i) begin
            tag_q[waddr_i] <= din_i[TVD_W-1:2];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wen_i) begin
            valid_q[waddr_i] <= din_i[1];
            dirty_q[waddr_i] <= din_i[0];
        end
    end

    // async read by set
    assign dout_o = {tag_q[raddr_i], valid_q[raddr_i], dirty_q[raddr_i]};

    // a write to an unknown set would corrupt every entry in simulation
    a_waddr_known: assert property (
        @(posedge clk) disable iff (rst)
        wen_i |-> !$isunknown(waddr_i)
    );

endmodule

`default_nettype wire

/* source/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // bus widths
    parameter int ADDR_W = 32;  // byte address
    parameter int DATA_W = 32;
    parameter int SEL_W  = DATA_W / 8;

    // controller states
    typedef enum logic [2:0] {
        S_IDLE   = 3'd0,  // waiting for cyc/stb
        S_LOOKUP = 3'd1,  // tag compare, hit ack
        S_WBACK  = 3'd2,  // dirty victim out to memory
        S_REFILL = 3'd3,  // line in from memory
        S_DONE   = 3'd4   // finish refilled access
    } cache_state_t;

    // request kind taken from cpu we
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cache_op_t;

endpackage

`default_nettype wire
